//--- src.f
verilog/lab4_bus_pkg.sv
verilog/lab4_chip_pkg.sv
verilog/lab4_reg_bank.sv
verilog/lab4_cmd_fifo.sv
verilog/lab4_serial_engine.sv
verilog/lab4_serial_ctrl.sv
test/lab4_serial_checker.sv
test/tb_lab4_serial_ctrl.sv

//--- Bender.yml
package:
  name: lab4_serial_ctrl

sources:
  - verilog/lab4_bus_pkg.sv
  - verilog/lab4_chip_pkg.sv
  - verilog/lab4_reg_bank.sv
  - verilog/lab4_cmd_fifo.sv
  - verilog/lab4_serial_engine.sv
  - verilog/lab4_serial_ctrl.sv
  - target: test
    files:
      - test/lab4_serial_checker.sv
      - test/tb_lab4_serial_ctrl.sv

//--- test/tb_lab4_serial_ctrl.sv
`default_nettype none

module tb_lab4_serial_ctrl;
	timeunit 1ns;
	timeprecision 1ns;

	logic                                    clk;
	logic                                    rst_n;
	logic                                    wb_cyc;
	logic                                    wb_stb;
	logic                                    wb_we;
	logic [lab4_bus_pkg::WB_ADR_WIDTH-1:0]   wb_adr;
	logic [lab4_bus_pkg::WB_DAT_WIDTH-1:0]   wb_dat_w;
	logic [lab4_bus_pkg::WB_DAT_WIDTH-1:0]   wb_dat_r;
	logic                                    wb_ack;
	logic [lab4_chip_pkg::NUM_LAB-1:0]       sin;
	logic [lab4_chip_pkg::NUM_LAB-1:0]       sclk;
	logic [lab4_chip_pkg::NUM_LAB-1:0]       pclk;
	logic [lab4_chip_pkg::NUM_LAB-1:0]       regclear;
	logic [lab4_bus_pkg::PRESCALE_WIDTH-1:0] exp_prescale;
	logic                                    timing_en;

	integer      seed = 32'ha675_4b57;
	int unsigned cycle_count = 0;
	int unsigned cycle_limit = 300;
	int          tests_run = 0;
	int          errors_before = 0;
	int          words_before;
	int          chip;
	logic [31:0] rd;
	logic [11:0] regclear_val;

	// model of the command path
	bit model_idle;
	int model_fill;
	bit model_overflow;

	always #5 clk = ~clk;

	lab4_serial_ctrl u_lab4_serial_ctrl (
		.clk_i      (clk),
		.rst_n_i    (rst_n),
		.wb_cyc_i   (wb_cyc),
		.wb_stb_i   (wb_stb),
		.wb_we_i    (wb_we),
		.wb_adr_i   (wb_adr),
		.wb_dat_i   (wb_dat_w),
		.wb_dat_o   (wb_dat_r),
		.wb_ack_o   (wb_ack),
		.sin_o      (sin),
		.sclk_o     (sclk),
		.pclk_o     (pclk),
		.regclear_o (regclear)
	);

	lab4_serial_checker u_checker (
		.clk_i       (clk),
		.rst_n_i     (rst_n),
		.sin_i       (sin),
		.sclk_i      (sclk),
		.pclk_i      (pclk),
		.prescale_i  (exp_prescale),
		.timing_en_i (timing_en)
	);

	function automatic int unsigned rand_below(input int unsigned n);
		return $unsigned($random(seed)) % n;
	endfunction

	function automatic logic [23:0] rand_word();
		return 24'($random(seed));
	endfunction

	// 24 bits of two phases plus the latch pulse
	function automatic int cmd_cycles(input logic [7:0] p);
		return 49 * (int'(p) + 1) + 4;
	endfunction

	task automatic add_budget(input int n);
		cycle_limit += n;
	endtask

	// ack is due on the first falling edge after the request
	task automatic wait_ack();
		int waited;
		waited = 1;
		@(negedge clk);
		while (!wb_ack) begin
			waited++;
			@(negedge clk);
		end
		u_checker.compare("ack delay in cycles", 32'(waited), 32'd1);
	endtask

	// idle cycle between accesses in which ack has dropped
	task automatic release_bus();
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we  = 1'b0;
		@(negedge clk);
		u_checker.compare("ack one cycle later", 32'(wb_ack), 32'd0);
	endtask

	task automatic bus_write(input logic [1:0] idx, input logic [31:0] data);
		wb_cyc   = 1'b1;
		wb_stb   = 1'b1;
		wb_we    = 1'b1;
		wb_adr   = {idx, 2'b00};
		wb_dat_w = data;
		wait_ack();
		release_bus();
	endtask

	task automatic bus_read(input logic [1:0] idx, output logic [31:0] data);
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we  = 1'b0;
		wb_adr = {idx, 2'b00};
		wait_ack();
		data = wb_dat_r;
		release_bus();
	endtask

	task automatic set_prescale(input logic [7:0] p);
		exp_prescale = p;
		bus_write(lab4_bus_pkg::REG_SHIFT_PRESCALE, {24'd0, p});
	endtask

	task automatic send_cmd(input logic [3:0] sel, input logic [23:0] data);
		bit taken;
		bus_write(lab4_bus_pkg::REG_USER_WRITE, {1'b1, 3'b000, sel, data});
		add_budget(cmd_cycles(exp_prescale));
		// idle engine takes it at once, else it waits in the buffer if there is room
		taken = model_idle || model_fill < lab4_chip_pkg::CMD_DEPTH;
		if (model_idle) begin
			model_idle = 1'b0;
		end else if (taken) begin
			model_fill++;
		end else begin
			model_overflow = 1'b1;
		end
		for (int i = 0; i < lab4_chip_pkg::NUM_LAB; i++) begin
			if (taken && (sel == i || sel == lab4_chip_pkg::SELECT_BROADCAST)) begin
				u_checker.expect_word(i, data);
			end
		end
	endtask

	task automatic wait_idle();
		logic [31:0] status;
		status = 32'h8000_0000;
		while (status[31]) begin
			bus_read(lab4_bus_pkg::REG_USER_WRITE, status);
		end
		model_idle = 1'b1;
		model_fill = 0;
	endtask

	task automatic idle_cycles(input int n);
		add_budget(n);
		repeat (n) @(negedge clk);
	endtask

	task automatic report_test(input string name);
		int n;
		n = u_checker.error_count - errors_before;
		errors_before = u_checker.error_count;
		tests_run++;
		// bus traffic allowance for the next test
		add_budget(200);
		if (n == 0) begin
			$display("%s: ok", name);
		end else begin
			$display("%s: %0d errors", name, n);
		end
	endtask

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count > cycle_limit) begin
			$display("timeout: run went past its limit of %0d cycles", cycle_limit);
			$display("=== FAIL ===");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////
	// test sequence
	////////////////////////////////////////////////////////////

	initial begin
		clk            = 1'b0;
		rst_n          = 1'b0;
		wb_cyc         = 1'b0;
		wb_stb         = 1'b0;
		wb_we          = 1'b0;
		wb_adr         = '0;
		wb_dat_w       = '0;
		exp_prescale   = '0;
		timing_en      = 1'b1;
		model_idle     = 1'b1;
		model_fill     = 0;
		model_overflow = 1'b0;
		repeat (5) @(negedge clk);
		rst_n = 1'b1;

		bus_read(lab4_bus_pkg::REG_CONTROL, rd);
		u_checker.compare("control after reset", rd, '0);
		bus_read(lab4_bus_pkg::REG_SHIFT_PRESCALE, rd);
		u_checker.compare("prescale after reset", rd, '0);
		bus_read(lab4_bus_pkg::REG_USER_WRITE, rd);
		u_checker.compare("busy and overflow after reset", 32'(rd[31:30]), '0);
		u_checker.compare("regclear_o after reset", 32'(regclear), '0);
		regclear_val = 12'(rand_below(4096));
		bus_write(lab4_bus_pkg::REG_CONTROL, {4'b0, regclear_val, 16'h0});
		bus_read(lab4_bus_pkg::REG_CONTROL, rd);
		u_checker.compare("control readback", rd, {4'b0, regclear_val, 16'h0});
		u_checker.compare("regclear_o", 32'(regclear), 32'(regclear_val));
		report_test("test 1 reset values and regclear");

		set_prescale(8'(rand_below(4)));
		repeat (4) begin
			send_cmd(4'(rand_below(12)), rand_word());
			wait_idle();
		end
		u_checker.check_drained();
		report_test("test 2 single chip words");

		set_prescale(8'(rand_below(4)));
		send_cmd(4'd15, rand_word());
		for (int s = 12; s < 15; s++) begin
			send_cmd(4'(s), rand_word());
		end
		wait_idle();
		u_checker.check_drained();
		report_test("test 3 broadcast and unused selects");

		repeat (3) begin
			set_prescale(8'(rand_below(24)));
			chip = rand_below(13);
			send_cmd(chip == 12 ? 4'd15 : 4'(chip), rand_word());
			wait_idle();
		end
		u_checker.check_drained();
		report_test("test 4 random prescale timing");

		// long prescale so the whole burst lands while the first word shifts
		set_prescale(8'd40);
		chip         = rand_below(12);
		words_before = u_checker.words_seen;
		repeat (lab4_chip_pkg::CMD_DEPTH + 2) begin
			send_cmd(4'(chip), rand_word());
		end
		bus_read(lab4_bus_pkg::REG_USER_WRITE, rd);
		u_checker.compare("overflow flag", 32'(rd[30]), 32'(model_overflow));
		wait_idle();
		u_checker.compare("words delivered", 32'(u_checker.words_seen - words_before),
		                  32'(lab4_chip_pkg::CMD_DEPTH + 1));
		u_checker.check_drained();
		report_test("test 5 buffer overflow");

		set_prescale(8'd3);
		chip = rand_below(12);
		repeat (3) begin
			send_cmd(4'(chip), rand_word());
		end
		idle_cycles(60);
		timing_en = 1'b0;
		bus_write(lab4_bus_pkg::REG_CONTROL, {4'b0, regclear_val, 15'b0, 1'b1});
		@(negedge clk);
		u_checker.compare("pins after abort", 32'(sin | sclk | pclk), '0);
		bus_read(lab4_bus_pkg::REG_USER_WRITE, rd);
		u_checker.compare("busy after abort", 32'(rd[31]), '0);
		u_checker.clear_state();
		timing_en  = 1'b1;
		model_idle = 1'b1;
		model_fill = 0;
		// any word still coming out now is unexpected
		idle_cycles(3 * cmd_cycles(8'd3));
		u_checker.check_drained();
		report_test("test 6 abort by serial reset");

		$display("tests run: %0d, errors: %0d", tests_run, u_checker.error_count);
		if (u_checker.error_count == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- test/lab4_serial_checker.sv
`default_nettype none

module lab4_serial_checker (
	input  wire logic                                    clk_i,
	input  wire logic                                    rst_n_i,
	input  wire logic [lab4_chip_pkg::NUM_LAB-1:0]       sin_i,
	input  wire logic [lab4_chip_pkg::NUM_LAB-1:0]       sclk_i,
	input  wire logic [lab4_chip_pkg::NUM_LAB-1:0]       pclk_i,
	input  wire logic [lab4_bus_pkg::PRESCALE_WIDTH-1:0] prescale_i,
	input  wire logic                                    timing_en_i
);
	timeunit 1ns;
	timeprecision 1ns;

	localparam int NL = lab4_chip_pkg::NUM_LAB;
	localparam int SW = lab4_chip_pkg::SERIAL_WIDTH;

	// expected words in arrival order, chip and data side by side
	int            exp_chip [$];
	logic [SW-1:0] exp_data [$];

	logic [NL-1:0] sclk_q;
	logic [NL-1:0] pclk_q;
	logic [SW-1:0] word [NL];
	int            bit_cnt [NL];
	int            high_len [NL];
	int            low_len [NL];
	int            pclk_len [NL];
	bit            low_valid [NL];
	int            error_count = 0;
	int            words_seen = 0;

	task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("Fail at %0d ns: %s is %h, expected %h", $time, what, got, exp);
			error_count++;
		end
	endtask

	task automatic expect_word(input int chip, input logic [SW-1:0] data);
		exp_chip.push_back(chip);
		exp_data.push_back(data);
	endtask

	// forget queued words and any half shifted word
	task automatic clear_state();
		exp_chip.delete();
		exp_data.delete();
		for (int i = 0; i < NL; i++) begin
			bit_cnt[i]   = 0;
			low_valid[i] = 1'b0;
		end
	endtask

	task automatic check_len(input int chip, input string what, input int len);
		if (timing_en_i && len != int'(prescale_i) + 1) begin
			$display("Fail at %0d ns: chip %0d %s lasted %0d cycles, expected %0d",
			         $time, chip, what, len, int'(prescale_i) + 1);
			error_count++;
		end
	endtask

	task automatic latch_word(input int chip);
		int idx;
		idx = -1;
		// oldest word still owed to this chip
		for (int k = 0; k < exp_chip.size(); k++) begin
			if (idx < 0 && exp_chip[k] == chip) begin
				idx = k;
			end
		end
		words_seen++;
		if (bit_cnt[chip] != SW) begin
			$display("Fail at %0d ns: chip %0d latched after %0d bits, expected %0d",
			         $time, chip, bit_cnt[chip], SW);
			error_count++;
		end
		if (idx < 0) begin
			$display("Fail at %0d ns: chip %0d latched %h with no word expected",
			         $time, chip, word[chip]);
			error_count++;
		end else begin
			if (word[chip] !== exp_data[idx]) begin
				$display("Fail at %0d ns: chip %0d latched %h, expected %h",
				         $time, chip, word[chip], exp_data[idx]);
				error_count++;
			end
			exp_chip.delete(idx);
			exp_data.delete(idx);
		end
	endtask

	task automatic check_drained();
		if (exp_chip.size() != 0) begin
			$display("%0d expected words never arrived by %0d ns", exp_chip.size(), $time);
			error_count++;
		end
		for (int i = 0; i < NL; i++) begin
			if (bit_cnt[i] != 0) begin
				$display("chip %0d was left with %0d bits shifted and no latch", i, bit_cnt[i]);
				error_count++;
			end
		end
	endtask

	////////////////////////////////////////////////////////////
	// pin watcher, one sample per falling edge
	////////////////////////////////////////////////////////////

	always @(negedge clk_i) begin
		if (!rst_n_i) begin
			clear_state();
			sclk_q = '0;
			pclk_q = '0;
		end else begin
			for (int i = 0; i < NL; i++) begin
				if (sclk_i[i] && !sclk_q[i]) begin
					// rising SCLK, SIN holds the bit
					if (low_valid[i]) begin
						check_len(i, "SCLK low", low_len[i]);
					end
					word[i] = {word[i][SW-2:0], sin_i[i]};
					bit_cnt[i]++;
					high_len[i] = 1;
				end else if (sclk_i[i]) begin
					high_len[i]++;
				end else if (sclk_q[i]) begin
					check_len(i, "SCLK high", high_len[i]);
					low_valid[i] = 1'b1;
					low_len[i]   = 1;
				end else begin
					low_len[i]++;
				end
				if (pclk_i[i] && !pclk_q[i]) begin
					low_valid[i] = 1'b0;
					latch_word(i);
					bit_cnt[i]  = 0;
					pclk_len[i] = 1;
				end else if (pclk_i[i]) begin
					pclk_len[i]++;
				end else if (pclk_q[i]) begin
					check_len(i, "PCLK", pclk_len[i]);
				end
			end
			sclk_q = sclk_i;
			pclk_q = pclk_i;
		end
	end

endmodule

`default_nettype wire

//--- verilog/lab4_serial_ctrl.sv
`default_nettype none

module lab4_serial_ctrl (
	input  wire logic                                  clk_i,
	input  wire logic                                  rst_n_i,
	input  wire logic                                  wb_cyc_i,
	input  wire logic                                  wb_stb_i,
	input  wire logic                                  wb_we_i,
	input  wire logic [lab4_bus_pkg::WB_ADR_WIDTH-1:0] wb_adr_i,
	input  wire logic [lab4_bus_pkg::WB_DAT_WIDTH-1:0] wb_dat_i,
	output logic      [lab4_bus_pkg::WB_DAT_WIDTH-1:0] wb_dat_o,
	output logic                                       wb_ack_o,
	output logic      [lab4_chip_pkg::NUM_LAB-1:0]     sin_o,
	output logic      [lab4_chip_pkg::NUM_LAB-1:0]     sclk_o,
	output logic      [lab4_chip_pkg::NUM_LAB-1:0]     pclk_o,
	output logic      [lab4_chip_pkg::NUM_LAB-1:0]     regclear_o
);

	logic [lab4_bus_pkg::PRESCALE_WIDTH-1:0] prescale;
	logic                                    cmd_push;
	logic [lab4_chip_pkg::CMD_WIDTH-1:0]     push_data;
	logic                                    flush;
	logic                                    cmd_pop;
	logic [lab4_chip_pkg::CMD_WIDTH-1:0]     head_data;
	logic                                    cmd_empty;
	logic                                    cmd_full;
	logic                                    engine_busy;

	lab4_reg_bank u_reg_bank (
		.clk_i         (clk_i),
		.rst_n_i       (rst_n_i),
		.wb_cyc_i      (wb_cyc_i),
		.wb_stb_i      (wb_stb_i),
		.wb_we_i       (wb_we_i),
		.wb_adr_i      (wb_adr_i),
		.wb_dat_i      (wb_dat_i),
		.wb_dat_o      (wb_dat_o),
		.wb_ack_o      (wb_ack_o),
		.regclear_o    (regclear_o),
		.prescale_o    (prescale),
		.cmd_push_o    (cmd_push),
		.cmd_data_o    (push_data),
		.flush_o       (flush),
		.cmd_full_i    (cmd_full),
		.cmd_empty_i   (cmd_empty),
		.engine_busy_i (engine_busy)
	);

	lab4_cmd_fifo u_cmd_fifo (
		.clk_i       (clk_i),
		.rst_n_i     (rst_n_i),
		.push_i      (cmd_push),
		.push_data_i (push_data),
		.pop_i       (cmd_pop),
		.flush_i     (flush),
		.data_o      (head_data),
		.empty_o     (cmd_empty),
		.full_o      (cmd_full)
	);

	// flush also aborts a transfer in flight
	lab4_serial_engine u_serial_engine (
		.clk_i       (clk_i),
		.rst_n_i     (rst_n_i),
		.cmd_empty_i (cmd_empty),
		.cmd_data_i  (head_data),
		.cmd_pop_o   (cmd_pop),
		.prescale_i  (prescale),
		.abort_i     (flush),
		.busy_o      (engine_busy),
		.sin_o       (sin_o),
		.sclk_o      (sclk_o),
		.pclk_o      (pclk_o)
	);

endmodule

`default_nettype wire

//--- verilog/lab4_serial_engine.sv
`default_nettype none

module lab4_serial_engine (
	input  wire logic                                    clk_i,
	input  wire logic                                    rst_n_i,
	input  wire logic                                    cmd_empty_i,
	input  wire logic [lab4_chip_pkg::CMD_WIDTH-1:0]     cmd_data_i,
	output logic                                         cmd_pop_o,
	input  wire logic [lab4_bus_pkg::PRESCALE_WIDTH-1:0] prescale_i,
	input  wire logic                                    abort_i,
	output logic                                         busy_o,
	output logic      [lab4_chip_pkg::NUM_LAB-1:0]       sin_o,
	output logic      [lab4_chip_pkg::NUM_LAB-1:0]       sclk_o,
	output logic      [lab4_chip_pkg::NUM_LAB-1:0]       pclk_o
);

	logic [lab4_chip_pkg::STATE_WIDTH-1:0]      state;
	logic [lab4_bus_pkg::PRESCALE_WIDTH-1:0]    presc_cnt;
	logic [lab4_bus_pkg::PRESCALE_WIDTH-1:0]    presc_lat;
	logic [lab4_chip_pkg::BIT_COUNT_WIDTH-1:0]  bit_cnt;
	logic [lab4_chip_pkg::SERIAL_WIDTH-1:0]     shreg;
	logic [lab4_chip_pkg::NUM_LAB-1:0]          chip_en;
	logic [lab4_chip_pkg::NUM_LAB-1:0]          pop_en;
	logic [lab4_chip_pkg::SELECT_WIDTH-1:0]     pop_select;
	logic                                       phase_done;

	assign pop_select = cmd_data_i[lab4_chip_pkg::CMD_WIDTH-1 -: lab4_chip_pkg::SELECT_WIDTH];

	// chip mask of the head command; 12 to 14 hit nothing
	always_comb begin
		for (int i = 0; i < lab4_chip_pkg::NUM_LAB; i++) begin
			pop_en[i] = (pop_select == i[lab4_chip_pkg::SELECT_WIDTH-1:0]) ||
			            (pop_select == lab4_chip_pkg::SELECT_BROADCAST);
		end
	end

	assign cmd_pop_o  = (state == lab4_chip_pkg::ST_IDLE) & ~cmd_empty_i & ~abort_i;
	assign busy_o     = (state != lab4_chip_pkg::ST_IDLE);
	assign phase_done = (presc_cnt == presc_lat);

	// word and mask, loaded at pop
	always_ff @(posedge clk_i) begin
		if (cmd_pop_o) begin
			shreg     <= cmd_data_i[lab4_chip_pkg::SERIAL_WIDTH-1:0];
			chip_en   <= pop_en;
			presc_lat <= prescale_i;
		end else if (state == lab4_chip_pkg::ST_SHIFT_HIGH && phase_done) begin
			shreg <= {shreg[lab4_chip_pkg::SERIAL_WIDTH-2:0], 1'b0};
		end
	end

	////////////////////////////////////////////////////////////
	// FSM, counters and chip pins
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_i) begin
		if (!rst_n_i || abort_i) begin
			state     <= lab4_chip_pkg::ST_IDLE;
			presc_cnt <= '0;
			bit_cnt   <= '0;
			sin_o     <= '0;
			sclk_o    <= '0;
			pclk_o    <= '0;
		end else begin
			presc_cnt <= phase_done ? '0 : presc_cnt + 1'b1;
			case (state)
				lab4_chip_pkg::ST_IDLE: begin
					presc_cnt <= '0;
					bit_cnt   <= '0;
					if (cmd_pop_o) begin
						// msb on SIN with SCLK low
						sin_o <= pop_en &
						         {lab4_chip_pkg::NUM_LAB{cmd_data_i[lab4_chip_pkg::SERIAL_WIDTH-1]}};
						state <= lab4_chip_pkg::ST_SHIFT_LOW;
					end
				end
				lab4_chip_pkg::ST_SHIFT_LOW: begin
					if (phase_done) begin
						sclk_o <= chip_en;
						state  <= lab4_chip_pkg::ST_SHIFT_HIGH;
					end
				end
				lab4_chip_pkg::ST_SHIFT_HIGH: begin
					if (phase_done) begin
						sclk_o <= '0;
						if (bit_cnt == lab4_chip_pkg::BIT_COUNT_LAST) begin
							sin_o  <= '0;
							pclk_o <= chip_en;
							state  <= lab4_chip_pkg::ST_LATCH;
						end else begin
							// next bit, shreg moves on the same edge
							sin_o   <= chip_en &
							           {lab4_chip_pkg::NUM_LAB{shreg[lab4_chip_pkg::SERIAL_WIDTH-2]}};
							bit_cnt <= bit_cnt + 1'b1;
							state   <= lab4_chip_pkg::ST_SHIFT_LOW;
						end
					end
				end
				default: begin
					// latch pulse, then back to idle
					if (phase_done) begin
						pclk_o <= '0;
						state  <= lab4_chip_pkg::ST_IDLE;
					end
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- verilog/lab4_cmd_fifo.sv
`default_nettype none

module lab4_cmd_fifo (
	input  wire logic                                 clk_i,
	input  wire logic                                 rst_n_i,
	input  wire logic                                 push_i,
	input  wire logic [lab4_chip_pkg::CMD_WIDTH-1:0]  push_data_i,
	input  wire logic                                 pop_i,
	input  wire logic                                 flush_i,
	output logic      [lab4_chip_pkg::CMD_WIDTH-1:0]  data_o,
	output logic                                      empty_o,
	output logic                                      full_o
);

	logic [lab4_chip_pkg::CMD_WIDTH-1:0]       mem [lab4_chip_pkg::CMD_DEPTH];
	logic [lab4_chip_pkg::CMD_PTR_WIDTH-1:0]   wr_ptr;
	logic [lab4_chip_pkg::CMD_PTR_WIDTH-1:0]   rd_ptr;
	logic [lab4_chip_pkg::CMD_COUNT_WIDTH-1:0] count;

	// storage, written at the tail
	always_ff @(posedge clk_i) begin
		if (push_i) begin
			mem[wr_ptr] <= push_data_i;
		end
	end

	////////////////////////////////////////////////////////////
	// pointers and fill count
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_i) begin
		if (!rst_n_i || flush_i) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push_i) begin
				if (wr_ptr == lab4_chip_pkg::CMD_PTR_LAST) begin
					wr_ptr <= '0;
				end else begin
					wr_ptr <= wr_ptr + 1'b1;
				end
			end
			if (pop_i) begin
				if (rd_ptr == lab4_chip_pkg::CMD_PTR_LAST) begin
					rd_ptr <= '0;
				end else begin
					rd_ptr <= rd_ptr + 1'b1;
				end
			end
			// push and pop together leave the count alone
			if (push_i && !pop_i) begin
				count <= count + 1'b1;
			end else if (pop_i && !push_i) begin
				count <= count - 1'b1;
			end
		end
	end

	// head shown ahead of pop
	assign data_o  = mem[rd_ptr];
	assign empty_o = (count == '0);
	assign full_o  = (count == lab4_chip_pkg::CMD_COUNT_FULL);

endmodule

`default_nettype wire

//--- verilog/lab4_reg_bank.sv
`default_nettype none

module lab4_reg_bank (
	input  wire logic                                   clk_i,
	input  wire logic                                   rst_n_i,
	input  wire logic                                   wb_cyc_i,
	input  wire logic                                   wb_stb_i,
	input  wire logic                                   wb_we_i,
	input  wire logic [lab4_bus_pkg::WB_ADR_WIDTH-1:0]  wb_adr_i,
	input  wire logic [lab4_bus_pkg::WB_DAT_WIDTH-1:0]  wb_dat_i,
	output logic      [lab4_bus_pkg::WB_DAT_WIDTH-1:0]  wb_dat_o,
	output logic                                        wb_ack_o,
	output logic      [lab4_chip_pkg::NUM_LAB-1:0]      regclear_o,
	output logic      [lab4_bus_pkg::PRESCALE_WIDTH-1:0] prescale_o,
	output logic                                        cmd_push_o,
	output logic      [lab4_chip_pkg::CMD_WIDTH-1:0]    cmd_data_o,
	output logic                                        flush_o,
	input  wire logic                                   cmd_full_i,
	input  wire logic                                   cmd_empty_i,
	input  wire logic                                   engine_busy_i
);

	logic                                       ack_q;
	logic                                       req;
	logic                                       wr_req;
	logic [1:0]                                 word_idx;
	lab4_bus_pkg::lab4_reg_word_u               wr_word;
	lab4_bus_pkg::lab4_reg_word_u               rd_word;

	logic [lab4_chip_pkg::NUM_LAB-1:0]          regclear_q;
	logic [lab4_bus_pkg::PRESCALE_WIDTH-1:0]    prescale_q;
	logic [lab4_chip_pkg::SERIAL_WIDTH-1:0]     user_data_q;
	logic [lab4_chip_pkg::SELECT_WIDTH-1:0]     user_select_q;
	logic                                       overflow_q;
	logic                                       serial_busy;

	// new request only, the ack cycle is not a second one
	assign req      = wb_cyc_i & wb_stb_i & ~ack_q;
	assign wr_req   = req & wb_we_i;
	assign word_idx = wb_adr_i[3:2];
	assign wr_word  = wb_dat_i;

	assign serial_busy = ~cmd_empty_i | engine_busy_i;

	////////////////////////////////////////////////////////////
	// write side
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			ack_q      <= 1'b0;
			regclear_q <= '0;
			prescale_q <= '0;
			overflow_q <= 1'b0;
			cmd_push_o <= 1'b0;
			flush_o    <= 1'b0;
		end else begin
			ack_q      <= req;
			cmd_push_o <= 1'b0;
			flush_o    <= 1'b0;
			if (wr_req && word_idx == lab4_bus_pkg::REG_CONTROL) begin
				regclear_q <= wr_word.ctrl.regclear;
				flush_o    <= wr_word.ctrl.serial_reset;
			end
			if (wr_req && word_idx == lab4_bus_pkg::REG_SHIFT_PRESCALE) begin
				prescale_q <= wb_dat_i[lab4_bus_pkg::PRESCALE_WIDTH-1:0];
			end
			// go is queued only while the buffer has room
			if (wr_req && word_idx == lab4_bus_pkg::REG_USER_WRITE && wr_word.user_write.go) begin
				if (cmd_full_i) begin
					overflow_q <= 1'b1;
				end else begin
					cmd_push_o <= 1'b1;
				end
			end
		end
	end

	// last user word and the queued command
	always_ff @(posedge clk_i) begin
		if (wr_req && word_idx == lab4_bus_pkg::REG_USER_WRITE) begin
			user_data_q   <= wr_word.user_write.data;
			user_select_q <= wr_word.user_write.select;
			cmd_data_o    <= {wr_word.user_write.select, wr_word.user_write.data};
		end
	end

	////////////////////////////////////////////////////////////
	// read side
	////////////////////////////////////////////////////////////

	always_comb begin
		rd_word = '0;
		case (word_idx)
			lab4_bus_pkg::REG_CONTROL: begin
				rd_word.ctrl.regclear = regclear_q;
			end
			lab4_bus_pkg::REG_SHIFT_PRESCALE: begin
				rd_word[lab4_bus_pkg::PRESCALE_WIDTH-1:0] = prescale_q;
			end
			lab4_bus_pkg::REG_USER_WRITE: begin
				rd_word.user_write.data     = user_data_q;
				rd_word.user_write.select   = user_select_q;
				rd_word.user_write.overflow = overflow_q;
				rd_word.user_write.go       = serial_busy;
			end
			default: begin
				rd_word = '0;
			end
		endcase
	end

	// data is valid with ack
	always_ff @(posedge clk_i) begin
		if (req) begin
			wb_dat_o <= rd_word;
		end
	end

	assign wb_ack_o   = ack_q;
	assign regclear_o = regclear_q;
	assign prescale_o = prescale_q;

endmodule

`default_nettype wire

//--- verilog/lab4_chip_pkg.sv
`default_nettype none

package lab4_chip_pkg;

	// chip array and serial word
	localparam int NUM_LAB      = 12;
	localparam int SERIAL_WIDTH = 24;
	localparam int SELECT_WIDTH = 4;

	// select that hits every chip
	localparam logic [SELECT_WIDTH-1:0] SELECT_BROADCAST = 4'd15;

	// command word: select above data
	localparam int CMD_WIDTH = SELECT_WIDTH + SERIAL_WIDTH;
	localparam int CMD_DEPTH = 4;

	localparam int CMD_PTR_WIDTH   = $clog2(CMD_DEPTH);
	localparam int CMD_COUNT_WIDTH = $clog2(CMD_DEPTH + 1);
	localparam logic [CMD_PTR_WIDTH-1:0]   CMD_PTR_LAST   = CMD_PTR_WIDTH'(CMD_DEPTH - 1);
	localparam logic [CMD_COUNT_WIDTH-1:0] CMD_COUNT_FULL = CMD_COUNT_WIDTH'(CMD_DEPTH);

	// bit counter of the shifter
	localparam int BIT_COUNT_WIDTH = $clog2(SERIAL_WIDTH);
	localparam logic [BIT_COUNT_WIDTH-1:0] BIT_COUNT_LAST = BIT_COUNT_WIDTH'(SERIAL_WIDTH - 1);

	// shifter states
	localparam int STATE_WIDTH = 2;
	localparam logic [STATE_WIDTH-1:0] ST_IDLE       = 2'd0;
	localparam logic [STATE_WIDTH-1:0] ST_SHIFT_LOW  = 2'd1;
	localparam logic [STATE_WIDTH-1:0] ST_SHIFT_HIGH = 2'd2;
	localparam logic [STATE_WIDTH-1:0] ST_LATCH      = 2'd3;

endpackage

`default_nettype wire

//--- verilog/lab4_bus_pkg.sv
`default_nettype none

package lab4_bus_pkg;

	////////////////////////////////////////////////////////////
	// bus geometry
	////////////////////////////////////////////////////////////

	// byte address, word index in bits 3:2
	localparam int WB_ADR_WIDTH = 4;
	localparam int WB_DAT_WIDTH = 32;

	// word indices
	localparam logic [1:0] REG_CONTROL        = 2'd0;
	localparam logic [1:0] REG_SHIFT_PRESCALE = 2'd1;
	localparam logic [1:0] REG_USER_WRITE     = 2'd2;
	localparam logic [1:0] REG_STATUS_UNUSED  = 2'd3;

	localparam int PRESCALE_WIDTH = 8;

	////////////////////////////////////////////////////////////
	// register word, decoded per address
	////////////////////////////////////////////////////////////

	typedef union packed {
		// control word
		struct packed {
			logic [3:0]  reserved_hi;
			logic [11:0] regclear;
			logic [14:0] reserved_lo;
			logic        serial_reset;
		} ctrl;
		// serial user write word
		struct packed {
			// busy when read back
			logic        go;
			logic        overflow;
			logic [1:0]  reserved;
			logic [3:0]  select;
			logic [23:0] data;
		} user_write;
	} lab4_reg_word_u;

endpackage

`default_nettype wire
